// ==== src/hbic_defs.svh ====
`ifndef HBIC_DEFS_SVH
`define HBIC_DEFS_SVH

// frame-pipeline masters sharing the controller
`define HBIC_PORTS    4

`define HBIC_ADDR_W   32
`define HBIC_DATA_W   128
`define HBIC_ID_W     4

// burst length field holds beats minus one
`define HBIC_LEN_W    8

// write commands issued but not yet fully forwarded
`define HBIC_WQ_DEPTH 4

`endif

// ==== src/hbic_cmd_pkg.sv ====
`default_nettype none

`include "hbic_defs.svh"

package hbic_cmd_pkg;

	typedef logic [$clog2(`HBIC_PORTS)-1:0] port_idx_t;

	// one port's aw or ar request
	typedef struct packed {
		logic [`HBIC_ADDR_W-1:0] addr;
		logic [`HBIC_LEN_W-1:0]  len;    // beats minus one
	} addr_req_t;

	// merged command toward the controller
	typedef struct packed {
		logic [`HBIC_ID_W-1:0]   id;     // originating port
		logic [`HBIC_ADDR_W-1:0] addr;
		logic [`HBIC_LEN_W-1:0]  len;
		logic                    write;  // 1 write, 0 read
	} arw_cmd_t;

endpackage

`default_nettype wire

// ==== src/hbic_beat_pkg.sv ====
`default_nettype none

`include "hbic_defs.svh"

package hbic_beat_pkg;

	// write beat, no id since order follows issued commands
	typedef struct packed {
		logic [`HBIC_DATA_W-1:0]   data;
		logic [`HBIC_DATA_W/8-1:0] strb;  // byte enables
		logic                      last;
	} wbeat_t;

	// read beat from the controller
	typedef struct packed {
		logic [`HBIC_ID_W-1:0]     id;    // destination port
		logic [`HBIC_DATA_W-1:0]   data;
		logic                      last;
		logic [1:0]                resp;
	} rbeat_t;

endpackage

`default_nettype wire

// ==== src/port_arbiter.sv ====
`default_nettype none

`include "hbic_defs.svh"

module port_arbiter (
	input  wire                          sys_clk_i,
	input  wire                          rst_n_i,
	input  wire [`HBIC_PORTS-1:0]        req_valid_i,
	input  wire hbic_cmd_pkg::addr_req_t req_i [`HBIC_PORTS],
	output logic [`HBIC_PORTS-1:0]       req_ready_o,
	output logic                         slot_valid_o,
	output hbic_cmd_pkg::addr_req_t      slot_o,
	output hbic_cmd_pkg::port_idx_t      slot_port_o,
	input  wire                          slot_ready_i
);

	import hbic_cmd_pkg::*;

	port_idx_t ptr_q;    // first port searched next
	port_idx_t win_idx;
	port_idx_t cand;
	logic      found;
	logic      load_en;

	assign load_en = !slot_valid_o || slot_ready_i;  // slot empty or draining

	// rotate from ptr_q, first requester wins
	always_comb begin
		found   = 1'b0;
		win_idx = ptr_q;
		cand    = ptr_q;
		for (int i = 0; i < `HBIC_PORTS; i++) begin
			cand = port_idx_t'(ptr_q + i);  // wraps at port count
			if (!found && req_valid_i[cand]) begin
				found   = 1'b1;
				win_idx = cand;
			end
		end
	end

	always_comb begin
		req_ready_o = '0;
		if (found && load_en) begin
			req_ready_o[win_idx] = 1'b1;  // one-cycle ready in the load cycle
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (!rst_n_i) begin
			slot_valid_o <= 1'b0;
			ptr_q        <= '0;
		end else if (load_en) begin
			slot_valid_o <= found;
			if (found) begin
				ptr_q <= win_idx + 1'b1;  // port after the winner
			end
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (load_en && found) begin
			slot_o      <= req_i[win_idx];
			slot_port_o <= win_idx;
		end
	end

	a_one_grant: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
		$onehot0(req_ready_o));

endmodule

`default_nettype wire

// ==== src/arw_merge.sv ====
`default_nettype none

`include "hbic_defs.svh"

module arw_merge (
	input  wire                          sys_clk_i,
	input  wire                          rst_n_i,
	input  wire                          aw_valid_i,
	input  wire hbic_cmd_pkg::addr_req_t aw_i,
	input  wire hbic_cmd_pkg::port_idx_t aw_port_i,
	output logic                         aw_ready_o,
	input  wire                          ar_valid_i,
	input  wire hbic_cmd_pkg::addr_req_t ar_i,
	input  wire hbic_cmd_pkg::port_idx_t ar_port_i,
	output logic                         ar_ready_o,
	input  wire                          wq_space_i,
	output logic                         wq_push_o,
	output hbic_cmd_pkg::port_idx_t      wq_port_o,
	output logic                         cmd_valid_o,
	output hbic_cmd_pkg::arw_cmd_t       cmd_o,
	input  wire                          cmd_ready_i
);

	import hbic_cmd_pkg::*;

	localparam int ID_W = `HBIC_ID_W;

	logic     cmd_free;
	logic     aw_ok;
	logic     take_w;
	logic     take_r;
	logic     wr_pri_q;  // write wins the next tie
	arw_cmd_t cmd_d;

	assign cmd_free = !cmd_valid_o || cmd_ready_i;
	assign aw_ok    = aw_valid_i && wq_space_i;  // write needs a queue entry
	assign take_w   = cmd_free && aw_ok && (wr_pri_q || !ar_valid_i);
	assign take_r   = cmd_free && ar_valid_i && !take_w;

	assign aw_ready_o = take_w;
	assign ar_ready_o = take_r;

	// write data order follows command order
	assign wq_push_o = take_w;
	assign wq_port_o = aw_port_i;

	always_comb begin
		cmd_d.write = take_w;
		if (take_w) begin
			cmd_d.id   = ID_W'(aw_port_i);
			cmd_d.addr = aw_i.addr;
			cmd_d.len  = aw_i.len;
		end else begin
			cmd_d.id   = ID_W'(ar_port_i);
			cmd_d.addr = ar_i.addr;
			cmd_d.len  = ar_i.len;
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (!rst_n_i) begin
			cmd_valid_o <= 1'b0;
			wr_pri_q    <= 1'b1;
		end else begin
			if (cmd_free) begin
				cmd_valid_o <= take_w || take_r;
			end
			if (take_w && ar_valid_i) begin
				wr_pri_q <= 1'b0;  // read goes first next time
			end else if (take_r && aw_ok) begin
				wr_pri_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (take_w || take_r) begin
			cmd_o <= cmd_d;
		end
	end

	a_cmd_hold: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
		cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o));

endmodule

`default_nettype wire

// ==== src/wdata_router.sv ====
`default_nettype none

`include "hbic_defs.svh"

module wdata_router (
	input  wire                           sys_clk_i,
	input  wire                           rst_n_i,
	input  wire                           push_i,
	input  wire hbic_cmd_pkg::port_idx_t  push_port_i,
	output logic                          space_o,
	input  wire [`HBIC_PORTS-1:0]         w_valid_i,
	input  wire hbic_beat_pkg::wbeat_t    w_i [`HBIC_PORTS],
	output logic [`HBIC_PORTS-1:0]        w_ready_o,
	output logic                          mw_valid_o,
	output hbic_beat_pkg::wbeat_t         mw_o,
	input  wire                           mw_ready_i
);

	import hbic_cmd_pkg::*;

	localparam int PTR_W = $clog2(`HBIC_WQ_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	port_idx_t        q_mem [`HBIC_WQ_DEPTH];  // ports of issued writes
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	port_idx_t        head;
	logic             empty;
	logic             pop;

	assign empty   = (count_q == '0);
	assign space_o = (count_q != CNT_W'(`HBIC_WQ_DEPTH));
	assign head    = q_mem[rd_ptr_q];

	// head port passes straight through
	assign mw_valid_o = !empty && w_valid_i[head];
	assign mw_o       = w_i[head];
	assign pop        = mw_valid_o && mw_ready_i && mw_o.last;  // burst done

	always_comb begin
		for (int i = 0; i < `HBIC_PORTS; i++) begin
			w_ready_o[i] = !empty && mw_ready_i && (head == port_idx_t'(i));
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (push_i && !pop) begin
				count_q <= count_q + 1'b1;
			end else if (pop && !push_i) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (push_i) begin
			q_mem[wr_ptr_q] <= push_port_i;
		end
	end

	// merge stage must honour space_o
	a_no_push_full: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
		push_i |-> count_q != CNT_W'(`HBIC_WQ_DEPTH));

endmodule

`default_nettype wire

// ==== src/rdata_router.sv ====
`default_nettype none

`include "hbic_defs.svh"

module rdata_router (
	input  wire                        mr_valid_i,
	input  wire hbic_beat_pkg::rbeat_t mr_i,
	output logic                       mr_ready_o,
	output logic [`HBIC_PORTS-1:0]     r_valid_o,
	output hbic_beat_pkg::rbeat_t      r_o,
	input  wire [`HBIC_PORTS-1:0]      r_ready_i
);

	import hbic_cmd_pkg::*;

	localparam int ID_W = `HBIC_ID_W;

	port_idx_t dst;

	assign dst = port_idx_t'(mr_i.id);  // id carries the port number
	assign r_o = mr_i;                  // payload shared by all ports

	always_comb begin
		for (int i = 0; i < `HBIC_PORTS; i++) begin
			r_valid_o[i] = mr_valid_i && (mr_i.id == ID_W'(i));
		end
	end

	assign mr_ready_o = r_ready_i[dst];

	// controller must echo an id issued by arw_merge
	always_comb begin
		if (mr_valid_i) begin
			a_id_range: assert (mr_i.id < ID_W'(`HBIC_PORTS))
				else $error("read beat id %0d has no port", mr_i.id);
		end
	end

endmodule

`default_nettype wire

// ==== src/hbic_top.sv ====
`default_nettype none

`include "hbic_defs.svh"

module hbic_top (
	input  wire                          sys_clk_i,
	input  wire                          rst_n_i,
	input  wire [`HBIC_PORTS-1:0]        aw_valid_i,
	input  wire hbic_cmd_pkg::addr_req_t aw_i [`HBIC_PORTS],
	output logic [`HBIC_PORTS-1:0]       aw_ready_o,
	input  wire [`HBIC_PORTS-1:0]        ar_valid_i,
	input  wire hbic_cmd_pkg::addr_req_t ar_i [`HBIC_PORTS],
	output logic [`HBIC_PORTS-1:0]       ar_ready_o,
	input  wire [`HBIC_PORTS-1:0]        w_valid_i,
	input  wire hbic_beat_pkg::wbeat_t   w_i [`HBIC_PORTS],
	output logic [`HBIC_PORTS-1:0]       w_ready_o,
	output logic [`HBIC_PORTS-1:0]       r_valid_o,
	output hbic_beat_pkg::rbeat_t        r_o [`HBIC_PORTS],
	input  wire [`HBIC_PORTS-1:0]        r_ready_i,
	output logic                         cmd_valid_o,
	output hbic_cmd_pkg::arw_cmd_t       cmd_o,
	input  wire                          cmd_ready_i,
	output logic                         mw_valid_o,
	output hbic_beat_pkg::wbeat_t        mw_o,
	input  wire                          mw_ready_i,
	input  wire                          mr_valid_i,
	input  wire hbic_beat_pkg::rbeat_t   mr_i,
	output logic                         mr_ready_o
);

	import hbic_cmd_pkg::*;
	import hbic_beat_pkg::*;

	logic      aw_slot_valid;
	addr_req_t aw_slot;
	port_idx_t aw_slot_port;
	logic      aw_slot_ready;
	logic      ar_slot_valid;
	addr_req_t ar_slot;
	port_idx_t ar_slot_port;
	logic      ar_slot_ready;
	logic      wq_push;
	port_idx_t wq_port;
	logic      wq_space;
	rbeat_t    r_beat;

	port_arbiter u_aw_arb (
		.sys_clk_i    (sys_clk_i),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (aw_valid_i),
		.req_i        (aw_i),
		.req_ready_o  (aw_ready_o),
		.slot_valid_o (aw_slot_valid),
		.slot_o       (aw_slot),
		.slot_port_o  (aw_slot_port),
		.slot_ready_i (aw_slot_ready)
	);

	port_arbiter u_ar_arb (
		.sys_clk_i    (sys_clk_i),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (ar_valid_i),
		.req_i        (ar_i),
		.req_ready_o  (ar_ready_o),
		.slot_valid_o (ar_slot_valid),
		.slot_o       (ar_slot),
		.slot_port_o  (ar_slot_port),
		.slot_ready_i (ar_slot_ready)
	);

	arw_merge u_arw_merge (
		.sys_clk_i   (sys_clk_i),
		.rst_n_i     (rst_n_i),
		.aw_valid_i  (aw_slot_valid),
		.aw_i        (aw_slot),
		.aw_port_i   (aw_slot_port),
		.aw_ready_o  (aw_slot_ready),
		.ar_valid_i  (ar_slot_valid),
		.ar_i        (ar_slot),
		.ar_port_i   (ar_slot_port),
		.ar_ready_o  (ar_slot_ready),
		.wq_space_i  (wq_space),
		.wq_push_o   (wq_push),
		.wq_port_o   (wq_port),
		.cmd_valid_o (cmd_valid_o),
		.cmd_o       (cmd_o),
		.cmd_ready_i (cmd_ready_i)
	);

	wdata_router u_wdata_router (
		.sys_clk_i   (sys_clk_i),
		.rst_n_i     (rst_n_i),
		.push_i      (wq_push),
		.push_port_i (wq_port),
		.space_o     (wq_space),
		.w_valid_i   (w_valid_i),
		.w_i         (w_i),
		.w_ready_o   (w_ready_o),
		.mw_valid_o  (mw_valid_o),
		.mw_o        (mw_o),
		.mw_ready_i  (mw_ready_i)
	);

	rdata_router u_rdata_router (
		.mr_valid_i (mr_valid_i),
		.mr_i       (mr_i),
		.mr_ready_o (mr_ready_o),
		.r_valid_o  (r_valid_o),
		.r_o        (r_beat),
		.r_ready_i  (r_ready_i)
	);

	for (genvar i = 0; i < `HBIC_PORTS; i++) begin : g_r_fanout
		assign r_o[i] = r_beat;  // only r_valid_o selects the port
	end

endmodule

`default_nettype wire

// ==== bench/tb_hbic_top.sv ====
`default_nettype none

`include "hbic_defs.svh"

module tb_hbic_top;

	import hbic_cmd_pkg::*;
	import hbic_beat_pkg::*;

	localparam int N_PORTS   = `HBIC_PORTS;
	localparam int ADDR_W    = `HBIC_ADDR_W;
	localparam int DATA_W    = `HBIC_DATA_W;
	localparam int LEN_W     = `HBIC_LEN_W;
	localparam int N_BURSTS  = 200;
	localparam int PER_PORT  = N_BURSTS / N_PORTS;
	localparam int MAX_BEATS = 4;
	localparam int TIMEOUT   = N_BURSTS * MAX_BEATS * 5;  // about five cycles per beat with stalls

	typedef struct packed {
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
	} req_rec_t;

	logic               clk;
	logic               rst_n;
	logic [N_PORTS-1:0] aw_valid;
	addr_req_t          aw_req [N_PORTS];
	logic [N_PORTS-1:0] aw_ready;
	logic [N_PORTS-1:0] ar_valid;
	addr_req_t          ar_req [N_PORTS];
	logic [N_PORTS-1:0] ar_ready;
	logic [N_PORTS-1:0] w_valid;
	wbeat_t             w_beat [N_PORTS];
	logic [N_PORTS-1:0] w_ready;
	logic [N_PORTS-1:0] r_valid;
	rbeat_t             r_beat [N_PORTS];
	logic [N_PORTS-1:0] r_ready;
	logic               cmd_valid;
	arw_cmd_t           cmd;
	logic               cmd_ready;
	logic               mw_valid;
	wbeat_t             mw;
	logic               mw_ready;
	logic               mr_valid;
	rbeat_t             mr;
	logic               mr_ready;

	logic [31:0]        lfsr = 32'habf489c6;
	int                 errors = 0;
	int                 cycles = 0;
	int                 n_cmds = 0;
	int                 n_wbeats = 0;
	int                 n_rbeats = 0;
	logic               started = 1'b0;
	int                 issued [N_PORTS];
	req_rec_t           sent_q [N_PORTS][$];    // requests not yet seen as commands
	logic [LEN_W-1:0]   wlen_q [N_PORTS][$];    // write bursts still to send
	int                 w_k [N_PORTS];
	req_rec_t           rd_exp_q [N_PORTS][$];  // reads waiting for data
	int                 r_k [N_PORTS];
	arw_cmd_t           wr_cmd_q [$];           // memory model, accepted writes
	arw_cmd_t           rd_cmd_q [$];
	int                 mw_k = 0;
	int                 mr_k = 0;
	int                 fair_cnt [2][N_PORTS][N_PORTS];
	logic               cmd_stall_q = 1'b0;
	arw_cmd_t           cmd_hold;
	logic               mw_stall_q = 1'b0;
	wbeat_t             mw_hold;
	logic [N_PORTS-1:0] r_stall_q = '0;
	rbeat_t             r_hold [N_PORTS];

	hbic_top u_hbic_top (
		.sys_clk_i   (clk),
		.rst_n_i     (rst_n),
		.aw_valid_i  (aw_valid),
		.aw_i        (aw_req),
		.aw_ready_o  (aw_ready),
		.ar_valid_i  (ar_valid),
		.ar_i        (ar_req),
		.ar_ready_o  (ar_ready),
		.w_valid_i   (w_valid),
		.w_i         (w_beat),
		.w_ready_o   (w_ready),
		.r_valid_o   (r_valid),
		.r_o         (r_beat),
		.r_ready_i   (r_ready),
		.cmd_valid_o (cmd_valid),
		.cmd_o       (cmd),
		.cmd_ready_i (cmd_ready),
		.mw_valid_o  (mw_valid),
		.mw_o        (mw),
		.mw_ready_i  (mw_ready),
		.mr_valid_i  (mr_valid),
		.mr_i        (mr),
		.mr_ready_o  (mr_ready)
	);

	always #5 clk = ~clk;

	initial begin
		clk       = 1'b0;
		rst_n     <= 1'b0;
		aw_valid  <= '0;
		ar_valid  <= '0;
		w_valid   <= '0;
		r_ready   <= '0;
		cmd_ready <= 1'b0;
		mw_ready  <= 1'b0;
		mr_valid  <= 1'b0;
		mr        <= '0;
		for (int p = 0; p < N_PORTS; p++) begin
			aw_req[p] <= '0;
			ar_req[p] <= '0;
			w_beat[p] <= '0;
			issued[p] = 0;
			w_k[p]    = 0;
			r_k[p]    = 0;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end

	// fibonacci lfsr, one step per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// port number above beat number
	function automatic logic [DATA_W-1:0] wdata_of(input int p, input int k);
		return (DATA_W'(p) << 8) | DATA_W'(k);
	endfunction

	task automatic expect_equal(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		a_equal: assert (got == exp) else begin
			errors++;
			$display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		a_true: assert (cond) else begin
			errors++;
			$display("%0t %s", $time, what);
		end
	endtask

	task automatic check_reset_outputs();
		expect_equal("aw_ready_o", DATA_W'(aw_ready), '0);
		expect_equal("ar_ready_o", DATA_W'(ar_ready), '0);
		expect_equal("w_ready_o", DATA_W'(w_ready), '0);
		expect_equal("r_valid_o", DATA_W'(r_valid), '0);
		expect_equal("cmd_valid_o", DATA_W'(cmd_valid), '0);
		expect_equal("mw_valid_o", DATA_W'(mw_valid), '0);
		expect_equal("mr_ready_o", DATA_W'(mr_ready), '0);
	endtask

	// a stalled output keeps valid and payload
	task automatic check_stalls();
		if (cmd_stall_q) begin
			expect_true(cmd_valid && cmd == cmd_hold, "command changed while stalled");
		end
		if (mw_stall_q) begin
			expect_true(mw_valid && mw == mw_hold, "memory write beat changed while stalled");
		end
		for (int p = 0; p < N_PORTS; p++) begin
			if (r_stall_q[p]) begin
				expect_true(r_valid[p] && r_beat[p] == r_hold[p],
					$sformatf("read beat to port %0d changed while stalled", p));
			end
			r_stall_q[p] = r_valid[p] && !r_ready[p];
			r_hold[p]    = r_beat[p];
		end
		cmd_stall_q = cmd_valid && !cmd_ready;
		cmd_hold    = cmd;
		mw_stall_q  = mw_valid && !mw_ready;
		mw_hold     = mw;
	endtask

	// grants to other ports while p keeps waiting
	task automatic track_fairness(input int ch, input logic [N_PORTS-1:0] v,
			input logic [N_PORTS-1:0] r);
		for (int p = 0; p < N_PORTS; p++) begin
			for (int q = 0; q < N_PORTS; q++) begin
				if (!v[p] || r[p]) begin
					fair_cnt[ch][p][q] = 0;
				end else if (q != p && r[q]) begin
					fair_cnt[ch][p][q]++;
					expect_true(fair_cnt[ch][p][q] < 2,
						$sformatf("%s arbiter granted port %0d twice while port %0d waited",
						(ch == 0) ? "aw" : "ar", q, p));
				end
			end
		end
	endtask

	task automatic accept_command();
		req_rec_t exp;
		int       p;
		int       idx;
		if (cmd_valid && cmd_ready) begin
			n_cmds++;
			p   = int'(cmd.id);
			idx = -1;
			if (p < N_PORTS) begin
				// aw and ar channels keep separate orders per port
				for (int i = 0; i < sent_q[p].size(); i++) begin
					if (idx < 0 && sent_q[p][i].write == cmd.write) begin
						idx = i;
					end
				end
			end
			if (idx < 0) begin
				expect_true(1'b0, $sformatf("%s command with id %0d has no outstanding request",
					cmd.write ? "write" : "read", p));
			end else begin
				exp = sent_q[p][idx];
				sent_q[p].delete(idx);
				expect_equal("cmd_o.addr", DATA_W'(cmd.addr), DATA_W'(exp.addr));
				expect_equal("cmd_o.len", DATA_W'(cmd.len), DATA_W'(exp.len));
				if (cmd.write) begin
					wr_cmd_q.push_back(cmd);
				end else begin
					rd_cmd_q.push_back(cmd);
				end
			end
		end
	endtask

	task automatic accept_write_beats();
		arw_cmd_t head;
		if (mw_valid && mw_ready) begin
			n_wbeats++;
			if (wr_cmd_q.size() == 0) begin
				expect_true(1'b0, "write beat arrived with no write command accepted");
			end else begin
				head = wr_cmd_q[0];
				expect_equal("mw_o.data", mw.data, wdata_of(int'(head.id), mw_k));
				expect_equal("mw_o.strb", DATA_W'(mw.strb), DATA_W'({(DATA_W/8){1'b1}}));
				expect_equal("mw_o.last", DATA_W'(mw.last), DATA_W'(mw_k == int'(head.len)));
				if (mw_k == int'(head.len)) begin
					void'(wr_cmd_q.pop_front());
					mw_k = 0;
				end else begin
					mw_k++;
				end
			end
		end
		for (int p = 0; p < N_PORTS; p++) begin
			if (w_valid[p] && w_ready[p]) begin
				if (w_k[p] == int'(wlen_q[p][0])) begin
					void'(wlen_q[p].pop_front());
					w_k[p] = 0;
				end else begin
					w_k[p]++;
				end
			end
		end
	endtask

	task automatic deliver_read_beats();
		arw_cmd_t           head;
		req_rec_t           exp;
		logic [N_PORTS-1:0] dst;
		dst = '0;
		if (mr_valid) begin
			dst[port_idx_t'(mr.id)] = 1'b1;
			expect_equal("mr_ready_o", DATA_W'(mr_ready), DATA_W'(r_ready[port_idx_t'(mr.id)]));
		end
		expect_equal("r_valid_o", DATA_W'(r_valid), DATA_W'(dst));
		if (mr_valid && mr_ready) begin
			head = rd_cmd_q[0];
			if (mr_k == int'(head.len)) begin
				void'(rd_cmd_q.pop_front());
				mr_k = 0;
			end else begin
				mr_k++;
			end
		end
		for (int p = 0; p < N_PORTS; p++) begin
			if (r_valid[p] && r_ready[p]) begin
				n_rbeats++;
				if (rd_exp_q[p].size() == 0) begin
					expect_true(1'b0, $sformatf("port %0d got a read beat it never asked for", p));
				end else begin
					exp = rd_exp_q[p][0];
					expect_equal($sformatf("r_o[%0d].data", p), r_beat[p].data,
						DATA_W'(exp.addr) + DATA_W'(r_k[p]));
					expect_equal($sformatf("r_o[%0d].id", p), DATA_W'(r_beat[p].id), DATA_W'(p));
					expect_equal($sformatf("r_o[%0d].last", p), DATA_W'(r_beat[p].last),
						DATA_W'(r_k[p] == int'(exp.len)));
					expect_equal($sformatf("r_o[%0d].resp", p), DATA_W'(r_beat[p].resp), '0);
					if (r_k[p] == int'(exp.len)) begin
						void'(rd_exp_q[p].pop_front());
						r_k[p] = 0;
					end else begin
						r_k[p]++;
					end
				end
			end
		end
	endtask

	task automatic drive_ports();
		req_rec_t rec;
		logic     busy;
		logic     go;
		for (int p = 0; p < N_PORTS; p++) begin
			busy = (aw_valid[p] && !aw_ready[p]) || (ar_valid[p] && !ar_ready[p]);
			go   = next_bits(2) != '0;  // idle a quarter of the time
			if (aw_ready[p]) begin
				aw_valid[p] <= 1'b0;
			end
			if (ar_ready[p]) begin
				ar_valid[p] <= 1'b0;
			end
			if (!busy && go && issued[p] < PER_PORT) begin
				rec.write = next_bits(1) != '0;
				rec.addr  = next_bits(ADDR_W);
				rec.len   = LEN_W'(next_bits(2));
				sent_q[p].push_back(rec);
				issued[p]++;
				if (rec.write) begin
					aw_valid[p]    <= 1'b1;
					aw_req[p].addr <= rec.addr;
					aw_req[p].len  <= rec.len;
					wlen_q[p].push_back(rec.len);
				end else begin
					ar_valid[p]    <= 1'b1;
					ar_req[p].addr <= rec.addr;
					ar_req[p].len  <= rec.len;
					rd_exp_q[p].push_back(rec);
				end
			end
			if (wlen_q[p].size() != 0) begin
				w_valid[p]     <= 1'b1;
				w_beat[p].data <= wdata_of(p, w_k[p]);
				w_beat[p].strb <= '1;
				w_beat[p].last <= (w_k[p] == int'(wlen_q[p][0]));
			end else begin
				w_valid[p] <= 1'b0;
			end
			r_ready[p] <= next_bits(2) != '0;
		end
	endtask

	task automatic drive_memory();
		logic     stall_cmd;
		logic     stall_mw;
		arw_cmd_t head;
		stall_cmd = next_bits(2) == '0;
		stall_mw  = next_bits(2) == '0;
		cmd_ready <= !stall_cmd;
		mw_ready  <= !stall_mw && wr_cmd_q.size() != 0;  // only beats of an accepted write
		if (rd_cmd_q.size() != 0) begin
			head = rd_cmd_q[0];
			mr_valid <= 1'b1;
			mr.id    <= head.id;
			mr.data  <= DATA_W'(head.addr) + DATA_W'(mr_k);
			mr.last  <= (mr_k == int'(head.len));
			mr.resp  <= 2'b00;
		end else begin
			mr_valid <= 1'b0;
		end
	endtask

	function automatic logic run_finished();
		logic done;
		done = wr_cmd_q.size() == 0 && rd_cmd_q.size() == 0 && !cmd_valid;
		for (int p = 0; p < N_PORTS; p++) begin
			done = done && issued[p] == PER_PORT && sent_q[p].size() == 0
				&& wlen_q[p].size() == 0 && rd_exp_q[p].size() == 0
				&& !aw_valid[p] && !ar_valid[p];
		end
		return done;
	endfunction

	task automatic end_run(input logic timed_out);
		if (timed_out) begin
			errors++;
			$display("%0t traffic still pending after %0d cycles", $time, TIMEOUT);
		end
		$display("summary: %0d errors, %0d commands, %0d write beats, %0d read beats",
			errors, n_cmds, n_wbeats, n_rbeats);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			cycles++;
			if (!started) begin
				check_reset_outputs();  // first edge after reset release
				started = 1'b1;
			end
			check_stalls();
			track_fairness(0, aw_valid, aw_ready);
			track_fairness(1, ar_valid, ar_ready);
			accept_command();
			accept_write_beats();
			deliver_read_beats();
			drive_ports();
			drive_memory();
			if (run_finished() || cycles >= TIMEOUT) begin
				end_run(!run_finished());
			end
		end
	end

endmodule

`default_nettype wire

// ==== hbic.f ====
+incdir+src
src/hbic_cmd_pkg.sv
src/hbic_beat_pkg.sv
src/port_arbiter.sv
src/arw_merge.sv
src/wdata_router.sv
src/rdata_router.sv
src/hbic_top.sv
bench/tb_hbic_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f hbic.f --top-module tb_hbic_top

status=0
output=$(./obj_dir/Vtb_hbic_top) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx 'TEST OK'; then
	exit 0
fi
exit 1
